/* Bender.yml */
package:
  name: stack_calc

sources:
  - include_dirs:
      - design
    files:
      - design/stack_pkg.sv
      - design/cmd_decode.sv
      - design/super_stack.sv
      - design/stack_exec.sv
      - design/stack_calc_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/stack_calc_assert.sv
      - sim/stack_calc_tb.sv

/* design/cmd_decode.sv */
`timescale 1ns/1ns
`include "stack_consts.svh"

module cmd_decode (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        instr_valid,
  input  stack_pkg::calc_instr_t      instr,
  output stack_pkg::exec_cmd_t        cmd,
  output logic [`STACK_ADDR_BITS:0]   underflow_limit
);
  import stack_pkg::*;

  // Highest legal limit, equal to the stack capacity
  localparam logic [`STACK_ADDR_BITS:0] LIMIT_MAX = {1'b1, {`STACK_ADDR_BITS{1'b0}}};

  stack_op_e                  dec_op;
  alu_fn_e                    dec_fn;
  logic [`STACK_ADDR_BITS:0]  lim_raw;
  logic [`STACK_ADDR_BITS:0]  lim_clamped;
  logic                       valid_q;
  stack_op_e                  op_q;
  alu_fn_e                    fn_q;
  logic [`IMM_WIDTH-1:0]      imm_q;

  // Opcode to stack operation and data source
  always_comb begin
    dec_op = S_NONE;
    dec_fn = A_IMM;
    case (instr.opcode)
      PUSH: dec_op = S_PUSH;
      POP:  dec_op = S_POP;
      ADD: begin
        dec_op = S_REPLACE;
        dec_fn = A_ADD;
      end
      SUB: begin
        dec_op = S_REPLACE;
        dec_fn = A_SUB;
      end
      DUP: begin
        dec_op = S_PUSH;
        dec_fn = A_TOS;
      end
      default: dec_op = S_NONE;  // NOP, PEEK and SETLIM leave the stack alone
    endcase
  end

  assign lim_raw     = instr.imm[`STACK_ADDR_BITS:0];
  assign lim_clamped = (lim_raw > LIMIT_MAX) ? LIMIT_MAX : lim_raw;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q         <= 1'b0;
      underflow_limit <= '0;
    end else begin
      valid_q <= instr_valid && (instr.opcode != NOP);  // NOP gives no result strobe
      if (instr_valid && (instr.opcode == SETLIM)) begin
        underflow_limit <= lim_clamped;
      end
    end
  end

  // Command payload, only meaningful while valid_q is set
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      op_q  <= dec_op;
      fn_q  <= dec_fn;
      imm_q <= instr.imm;
    end
  end

  assign cmd = '{valid: valid_q, op: op_q, fn: fn_q, imm: imm_q};

endmodule

/* design/stack_calc_top.sv */
`timescale 1ns/1ns
`include "stack_consts.svh"

module stack_calc_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       instr_valid,
  input  stack_pkg::calc_instr_t     instr,
  output logic                       result_valid,
  output stack_pkg::calc_result_t    result,
  output logic [`STACK_ADDR_BITS:0]  depth
);
  import stack_pkg::*;

  exec_cmd_t                  cmd;              // Decode to execute
  logic [`STACK_ADDR_BITS:0]  underflow_limit;  // Level, set by SETLIM

  // Stage 1
  cmd_decode u_decode (
    .clk             (clk),
    .reset           (reset),
    .instr_valid     (instr_valid),
    .instr           (instr),
    .cmd             (cmd),
    .underflow_limit (underflow_limit)
  );

  // Stage 2
  stack_exec u_exec (
    .clk             (clk),
    .reset           (reset),
    .cmd             (cmd),
    .underflow_limit (underflow_limit),
    .result_valid    (result_valid),
    .result          (result),
    .depth           (depth)
  );

endmodule

/* design/stack_consts.svh */
`ifndef STACK_CONSTS_SVH
`define STACK_CONSTS_SVH

// Width of one stack entry and of the result word
`define STACK_WIDTH 8

// Address bits of the stack storage
// The stack holds 1 << STACK_ADDR_BITS entries, so index and limit need one bit more
`define STACK_ADDR_BITS 4

// Immediate carried in each instruction, same width as a stack word
`define IMM_WIDTH `STACK_WIDTH

`endif

/* design/stack_exec.sv */
`timescale 1ns/1ns
`include "stack_consts.svh"

module stack_exec (
  input  logic                       clk,
  input  logic                       reset,
  input  stack_pkg::exec_cmd_t       cmd,
  input  logic [`STACK_ADDR_BITS:0]  underflow_limit,
  output logic                       result_valid,
  output stack_pkg::calc_result_t    result,
  output logic [`STACK_ADDR_BITS:0]  depth
);
  import stack_pkg::*;

  logic [`STACK_WIDTH-1:0]  tos;
  stack_status_e            status;
  stack_op_e                stack_op;
  logic [`STACK_WIDTH-1:0]  data_word;

  // Operand is the current top, already updated by the previous command
  always_comb begin
    case (cmd.fn)
      A_ADD:   data_word = tos + cmd.imm;  // Wraps modulo 256
      A_SUB:   data_word = tos - cmd.imm;
      A_TOS:   data_word = tos;
      default: data_word = cmd.imm;
    endcase
  end

  assign stack_op = cmd.valid ? cmd.op : S_NONE;

  super_stack #(
    .WIDTH     (`STACK_WIDTH),
    .ADDR_BITS (`STACK_ADDR_BITS)
  ) u_stack (
    .clk             (clk),
    .reset           (reset),
    .op              (stack_op),
    .data            (data_word),
    .underflow_limit (underflow_limit),
    .tos             (tos),
    .status          (status),
    .depth           (depth)
  );

  // Strobe lines up with the registered stack outputs
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= cmd.valid;
    end
  end

  assign result = '{tos: tos, status: status};

endmodule

/* design/stack_pkg.sv */
`include "stack_consts.svh"

package stack_pkg;

  // Calculator instruction set
  typedef enum logic [2:0] {
    NOP    = 3'd0,
    PUSH   = 3'd1,
    POP    = 3'd2,
    ADD    = 3'd3,
    SUB    = 3'd4,
    DUP    = 3'd5,
    SETLIM = 3'd6,
    PEEK   = 3'd7
  } calc_op_e;

  typedef enum logic [1:0] {
    S_NONE    = 2'd0,
    S_PUSH    = 2'd1,
    S_POP     = 2'd2,
    S_REPLACE = 2'd3
  } stack_op_e;

  // Source of the word written to the stack
  typedef enum logic [1:0] {
    A_IMM = 2'd0,  // Immediate as is
    A_ADD = 2'd1,  // Top plus immediate
    A_SUB = 2'd2,  // Top minus immediate
    A_TOS = 2'd3   // Copy of the top
  } alu_fn_e;

  typedef enum logic [1:0] {
    ST_NONE      = 2'd0,
    ST_EMPTY     = 2'd1,
    ST_UNDERFLOW = 2'd2,
    ST_OVERFLOW  = 2'd3
  } stack_status_e;

  typedef struct packed {
    calc_op_e               opcode;
    logic [`IMM_WIDTH-1:0]  imm;
  } calc_instr_t;

  typedef struct packed {
    logic                   valid;
    stack_op_e              op;
    alu_fn_e                fn;
    logic [`IMM_WIDTH-1:0]  imm;
  } exec_cmd_t;

  typedef struct packed {
    logic [`STACK_WIDTH-1:0] tos;
    stack_status_e           status;
  } calc_result_t;

endpackage

/* design/super_stack.sv */
`timescale 1ns/1ns
`include "stack_consts.svh"

module super_stack #(
  parameter int WIDTH     = `STACK_WIDTH,
  parameter int ADDR_BITS = `STACK_ADDR_BITS
) (
  input  logic                      clk,
  input  logic                      reset,
  input  stack_pkg::stack_op_e      op,
  input  logic [WIDTH-1:0]          data,
  input  logic [ADDR_BITS:0]        underflow_limit,
  output logic [WIDTH-1:0]          tos,
  output stack_pkg::stack_status_e  status,
  output logic [ADDR_BITS:0]        depth
);
  import stack_pkg::*;

  localparam int ENTRIES = 1 << ADDR_BITS;
  localparam logic [ADDR_BITS:0] FULL = {1'b1, {ADDR_BITS{1'b0}}};

  logic [WIDTH-1:0]      mem [ENTRIES];
  logic [ADDR_BITS:0]    index;        // Number of entries held
  logic [ADDR_BITS:0]    index_inc;
  logic [ADDR_BITS:0]    index_dec;
  logic [ADDR_BITS-1:0]  top_addr;     // Entry holding the top
  logic [ADDR_BITS-1:0]  under_addr;   // Entry just below the top
  logic                  full;
  logic                  above_limit;  // Something sits above the limit
  logic                  mem_we;
  logic [ADDR_BITS-1:0]  mem_waddr;

  // Status for a given fill level against the limit
  function automatic stack_status_e level_status(input logic [ADDR_BITS:0] idx,
                                                 input logic [ADDR_BITS:0] lim);
    if (idx < lim) begin
      return ST_UNDERFLOW;
    end else if (idx == lim) begin
      return ST_EMPTY;
    end
    return ST_NONE;
  endfunction

  assign index_inc   = index + 1'b1;
  assign index_dec   = index - 1'b1;
  assign top_addr    = index_dec[ADDR_BITS-1:0];
  assign under_addr  = top_addr - 1'b1;
  assign full        = (index == FULL);
  assign above_limit = (index > underflow_limit);
  assign depth       = index;

  always_comb begin
    mem_we    = 1'b0;
    mem_waddr = top_addr;
    case (op)
      S_PUSH: begin
        mem_we    = !full;
        mem_waddr = index[ADDR_BITS-1:0];  // Next free slot
      end
      S_REPLACE: mem_we = above_limit;
      default:   mem_we = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_waddr] <= data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      index  <= '0;
      status <= ST_EMPTY;
      tos    <= '0;
    end else begin
      case (op)
        S_NONE: begin
          status <= level_status(index, underflow_limit);  // Limit may have moved
          if (above_limit) begin
            tos <= mem[top_addr];
          end
        end
        S_PUSH: begin
          if (full) begin
            status <= ST_OVERFLOW;
          end else begin
            index  <= index_inc;
            tos    <= data;
            status <= level_status(index_inc, underflow_limit);
          end
        end
        S_POP: begin
          if (!above_limit) begin
            status <= ST_UNDERFLOW;
          end else begin
            index  <= index_dec;
            status <= (index_dec == underflow_limit) ? ST_EMPTY : ST_NONE;
            if (index_dec > underflow_limit) begin
              tos <= mem[under_addr];  // New top after the pop
            end
          end
        end
        S_REPLACE: begin
          if (!above_limit) begin
            status <= ST_UNDERFLOW;
          end else begin
            tos    <= data;
            status <= ST_NONE;
          end
        end
      endcase
    end
  end

endmodule

/* files.f */
+incdir+design
design/stack_pkg.sv
design/cmd_decode.sv
design/super_stack.sv
design/stack_exec.sv
design/stack_calc_top.sv
sim/stack_calc_assert.sv
sim/stack_calc_tb.sv

/* sim/stack_calc_assert.sv */
`timescale 1ns/1ns
`include "stack_consts.svh"

module stack_calc_assert (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       instr_valid,
  input  stack_pkg::calc_instr_t     instr,
  input  logic                       result_valid,
  input  stack_pkg::calc_result_t    result,
  input  logic [`STACK_ADDR_BITS:0]  depth
);
  import stack_pkg::*;

  logic issued;   // Instruction that must give a result
  logic pushing;  // Instruction that may overflow

  assign issued  = instr_valid && (instr.opcode != NOP);
  assign pushing = instr_valid && (instr.opcode == PUSH || instr.opcode == DUP);

  result_after_issue: assert property (@(posedge clk) disable iff (reset)
    issued |-> ##2 result_valid)
    else $error("Result strobe missing two cycles after an instruction");

  result_has_source: assert property (@(posedge clk) disable iff (reset)
    result_valid |-> $past(issued, 2))
    else $error("Result strobe without an instruction two cycles earlier");

  quiet_after_reset: assert property (@(posedge clk)
    $past(reset) |-> !result_valid)
    else $error("Result strobe in the cycle after reset");

  overflow_needs_push: assert property (@(posedge clk) disable iff (reset)
    (result.status == ST_OVERFLOW) |-> $past(pushing, 2))
    else $error("Overflow status not caused by a push");

  depth_in_range: assert property (@(posedge clk) disable iff (reset)
    depth <= (1 << `STACK_ADDR_BITS))
    else $error("Stack depth above capacity");

endmodule

bind stack_calc_top stack_calc_assert u_assert (
  .clk          (clk),
  .reset        (reset),
  .instr_valid  (instr_valid),
  .instr        (instr),
  .result_valid (result_valid),
  .result       (result),
  .depth        (depth)
);

/* sim/stack_calc_tb.sv */
`timescale 1ns/1ns
`include "stack_consts.svh"

module stack_calc_tb;
  import stack_pkg::*;

  localparam int ENTRIES      = 1 << `STACK_ADDR_BITS;
  localparam int MAX_CYCLES   = 2000;  // About three cycles per issued instruction
  localparam int DRAIN_CYCLES = 8;

  // One expected response as seen at the result strobe
  typedef struct packed {
    logic [`STACK_WIDTH-1:0]    tos;
    stack_status_e              status;
    logic [`STACK_ADDR_BITS:0]  depth;
  } expect_t;

  logic                       clk;
  logic                       reset;
  logic                       instr_valid;
  calc_instr_t                instr;
  logic                       result_valid;
  calc_result_t               result;
  logic [`STACK_ADDR_BITS:0]  depth;

  logic [`STACK_WIDTH-1:0]    model_mem [ENTRIES];  // Reference stack
  int                         model_idx;
  int                         model_lim;
  logic [`STACK_WIDTH-1:0]    model_tos;
  expect_t                    expected_q[$];        // Filled at issue time

  int error_count   = 0;
  int errors_before = 0;
  int check_count   = 0;
  int test_count    = 0;
  int cycle_count   = 0;

  stack_calc_top dut (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result       (result),
    .depth        (depth)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // Compare every strobed result with the oldest expected entry
  always @(posedge clk) begin
    expect_t want;
    if (!reset && result_valid) begin
      assert (expected_q.size() > 0) else begin
        error_count++;
        $display("Result strobe at %0t ns with no instruction outstanding", $time);
      end
      if (expected_q.size() > 0) begin
        want = expected_q.pop_front();
        check_count++;
        assert (result.tos == want.tos && result.status == want.status &&
                depth == want.depth) else begin
          error_count++;
          $display("ERROR at %0t ns: expected tos %0d %s depth %0d, got tos %0d %s depth %0d",
                   $time, want.tos, want.status.name(), want.depth,
                   result.tos, result.status.name(), depth);
        end
      end
    end
  end

  function automatic stack_status_e status_for_level(input int idx, input int lim);
    if (idx < lim) return ST_UNDERFLOW;
    if (idx == lim) return ST_EMPTY;
    return ST_NONE;
  endfunction

  // Reference model called once per accepted instruction
  task automatic apply_model(input calc_op_e op, input logic [`IMM_WIDTH-1:0] imm);
    logic [`STACK_WIDTH-1:0] word;
    stack_status_e           st;
    expect_t                 e;
    case (op)
      PUSH, DUP: begin
        word = (op == DUP) ? model_tos : imm;
        if (model_idx == ENTRIES) begin
          st = ST_OVERFLOW;  // Full so nothing moves
        end else begin
          model_mem[model_idx] = word;
          model_idx++;
          model_tos = word;
          st = status_for_level(model_idx, model_lim);
        end
      end
      POP: begin
        if (model_idx <= model_lim) begin
          st = ST_UNDERFLOW;
        end else begin
          model_idx--;
          st = (model_idx == model_lim) ? ST_EMPTY : ST_NONE;
          if (model_idx > model_lim) model_tos = model_mem[model_idx - 1];
        end
      end
      ADD, SUB: begin
        word = (op == ADD) ? model_tos + imm : model_tos - imm;  // Modulo 256
        if (model_idx <= model_lim) begin
          st = ST_UNDERFLOW;
        end else begin
          model_mem[model_idx - 1] = word;
          model_tos = word;
          st = ST_NONE;
        end
      end
      default: begin
        if (op == SETLIM) begin
          model_lim = (imm[`STACK_ADDR_BITS:0] > ENTRIES) ? ENTRIES : imm[`STACK_ADDR_BITS:0];
        end
        st = status_for_level(model_idx, model_lim);
        if (model_idx > model_lim) model_tos = model_mem[model_idx - 1];
      end
    endcase
    if (op != NOP) begin
      e = '{tos: model_tos, status: st, depth: model_idx[`STACK_ADDR_BITS:0]};
      expected_q.push_back(e);
    end
  endtask

  task automatic issue(input calc_op_e op, input logic [`IMM_WIDTH-1:0] imm);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = '{opcode: op, imm: imm};
    apply_model(op, imm);
  endtask

  task automatic idle();
    @(negedge clk);
    instr_valid = 1'b0;
    instr       = '0;
  endtask

  // Drain outstanding results, then report the test
  task automatic finish_test(input string name);
    int waited;
    int errs;
    idle();
    waited = 0;
    while (expected_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("%0d results of test %s never arrived", expected_q.size(), name);
      error_count += expected_q.size();
      expected_q.delete();
    end
    errs = error_count - errors_before;
    $display("Test %-14s %s, %0d errors", name, (errs == 0) ? "passed" : "FAILED", errs);
    errors_before = error_count;
    test_count++;
  endtask

  task automatic run_random(input int count);
    int               roll;
    bit               push_heavy;
    calc_op_e         op;
    logic [`IMM_WIDTH-1:0] imm;
    for (int i = 0; i < count; i++) begin
      push_heavy = ((i / 40) % 2) == 0;  // Alternate phases so depth sweeps 0 to 16
      roll = $urandom_range(0, 99);
      imm  = `IMM_WIDTH'($urandom);
      if (roll < 40) op = push_heavy ? PUSH : POP;
      else if (roll < 50) op = push_heavy ? DUP : POP;
      else if (roll < 62) op = push_heavy ? POP : PUSH;
      else if (roll < 72) op = ADD;
      else if (roll < 80) op = SUB;
      else if (roll < 88) op = PEEK;
      else if (roll < 94) op = NOP;
      else begin
        op = SETLIM;
        imm[4:0] = (roll < 98) ? 5'($urandom_range(0, 3)) : 5'($urandom_range(0, 31));
      end
      if ($urandom_range(0, 19) == 0) idle();  // Occasional gap
      issue(op, imm);
    end
  endtask

  initial begin
    void'($urandom(22));
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    model_idx   = 0;
    model_lim   = 0;
    model_tos   = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    repeat (5) issue(PUSH, `IMM_WIDTH'($urandom));
    repeat (5) issue(POP, '0);
    finish_test("lifo_order");

    repeat (17) issue(PUSH, `IMM_WIDTH'($urandom));  // Last one overflows
    issue(SETLIM, 8'h1f);  // Clamped to 16 so the full stack reads empty
    issue(PEEK, '0);
    issue(SETLIM, 8'd0);
    repeat (16) issue(POP, '0);
    finish_test("overflow");

    issue(POP, '0);
    repeat (4) issue(PUSH, `IMM_WIDTH'($urandom));
    issue(SETLIM, 8'd6);  // Above the depth of 4
    issue(PEEK, '0);
    issue(SETLIM, 8'd2);
    issue(PEEK, '0);
    issue(SETLIM, 8'd4);
    issue(PEEK, '0);
    issue(SETLIM, 8'he0);  // Upper bits ignored
    repeat (4) issue(POP, '0);
    finish_test("limit");

    issue(PUSH, 8'd250);
    issue(ADD, 8'd10);  // Wraps
    issue(SUB, 8'd7);
    issue(DUP, '0);
    issue(ADD, 8'd3);
    issue(SUB, 8'd200);
    issue(DUP, '0);
    issue(SETLIM, 8'd3);
    issue(ADD, 8'd1);  // Empty frame
    issue(SETLIM, 8'd0);
    repeat (3) issue(POP, '0);
    finish_test("arithmetic");

    run_random(400);
    finish_test("random_mix");

    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
